/* src/fpu_consts.svh */
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// Field widths of a single-precision word.
`define FPU_WORD_W   32
`define FPU_EXP_W    8
`define FPU_MANT_W   23
`define FPU_FUNCT_W  5
`define FPU_RM_W     3

`define FPU_EXP_BIAS 127

// Operation codes carried in funct5.
`define FPU_OP_FADD  5'b00000
`define FPU_OP_FSUB  5'b00001
`define FPU_OP_FMUL  5'b00010
`define FPU_OP_FSGNJ 5'b00100
`define FPU_OP_FCMP  5'b10100
`define FPU_OP_FTOI  5'b11000
`define FPU_OP_ITOF  5'b11010

// Sub-select codes in rm for sign injection and compare.
`define FPU_RM_SGNJ  3'b000
`define FPU_RM_SGNJN 3'b001
`define FPU_RM_SGNJX 3'b010
`define FPU_RM_FLE   3'b000
`define FPU_RM_FLT   3'b001
`define FPU_RM_FEQ   3'b010

`define FPU_CANON_NAN 32'h7fc00000

`endif

/* src/fpu_pkg.sv */
`include "fpu_consts.svh"

package fpu_pkg;

    // A float or an integer, depending on the operation.
    typedef logic [`FPU_WORD_W-1:0] fp_word_t;

    // Biased exponent field.
    typedef logic [`FPU_EXP_W-1:0] fp_exp_t;

    // Stored fraction without the hidden bit.
    typedef logic [`FPU_MANT_W-1:0] fp_mant_t;

    // Significand with the hidden bit in front.
    typedef logic [`FPU_MANT_W:0] fp_sig_t;

    typedef logic [`FPU_FUNCT_W-1:0] fp_funct_t;
    typedef logic [`FPU_RM_W-1:0] fp_rm_t;

endpackage

/* src/fpu_add.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_add
    import fpu_pkg::*;
    (
        input fp_word_t x,
        input fp_word_t y,
        input logic sub,
        output fp_word_t res
    );

    logic x_sign, y_sign;
    fp_exp_t x_exp, y_exp;
    fp_mant_t x_mant, y_mant;
    logic x_zero, y_zero, x_inf, y_inf, x_nan, y_nan;
    logic [30:0] x_mag, y_mag;
    logic x_big;

    logic a_sign, b_sign, eff_sub;
    fp_exp_t a_exp, b_exp, exp_diff;
    fp_sig_t a_sig, b_sig;
    logic [26:0] a_ext, b_ext, b_shift, lost_mask;
    logic [27:0] sum, norm;
    logic [4:0] lz;
    logic round_up;
    logic [24:0] sig_rnd;
    logic [9:0] exp_norm, exp_rnd;

    function automatic logic [4:0] lead_zeros(input logic [27:0] v);
        logic [4:0] n;
        logic found;
        n = '0;
        found = 1'b0;
        for (int i = 27; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 5'd1;
                end
            end
        end
        return n;
    endfunction

    // The sign of y is flipped here, so the datapath below only ever adds.
    assign x_sign = x[31];
    assign y_sign = y[31] ^ sub;
    assign x_exp = x[30:23];
    assign y_exp = y[30:23];
    assign x_mant = x[22:0];
    assign y_mant = y[22:0];

    // Subnormal inputs are read as zero.
    assign x_zero = (x_exp == '0);
    assign y_zero = (y_exp == '0);
    assign x_inf = (&x_exp) && (x_mant == '0);
    assign y_inf = (&y_exp) && (y_mant == '0);
    assign x_nan = (&x_exp) && (x_mant != '0);
    assign y_nan = (&y_exp) && (y_mant != '0);

    assign x_mag = x_zero ? '0 : x[30:0];
    assign y_mag = y_zero ? '0 : y[30:0];
    assign x_big = (x_mag >= y_mag);

    // Operand a always holds the larger magnitude.
    assign a_sign = x_big ? x_sign : y_sign;
    assign b_sign = x_big ? y_sign : x_sign;
    assign a_exp = x_big ? x_exp : y_exp;
    assign b_exp = x_big ? y_exp : x_exp;
    assign a_sig = x_big ? {!x_zero, x_mag[22:0]} : {!y_zero, y_mag[22:0]};
    assign b_sig = x_big ? {!y_zero, y_mag[22:0]} : {!x_zero, x_mag[22:0]};
    assign eff_sub = a_sign ^ b_sign;

    assign exp_diff = a_exp - b_exp;
    assign a_ext = {a_sig, 3'b000};
    assign b_ext = {b_sig, 3'b000};
    assign lost_mask = ~({27{1'b1}} << exp_diff);

    // Bits shifted past the round position collapse into the sticky bit.
    always_comb begin
        if (exp_diff >= 8'd27) begin
            b_shift = {26'b0, |b_ext};
        end else begin
            b_shift = b_ext >> exp_diff;
            b_shift[0] = b_shift[0] | (|(b_ext & lost_mask));
        end
    end

    assign sum = eff_sub ? ({1'b0, a_ext} - {1'b0, b_shift})
                         : ({1'b0, a_ext} + {1'b0, b_shift});

    // After the shift bit 27 is the hidden bit and bit 3 is the guard bit.
    assign lz = lead_zeros(sum);
    assign norm = sum << lz;
    assign exp_norm = {2'b0, a_exp} + 10'd1 - {5'b0, lz};

    assign round_up = norm[3] & ((|norm[2:0]) | norm[4]);
    assign sig_rnd = {1'b0, norm[27:4]} + {24'b0, round_up};
    assign exp_rnd = exp_norm + {9'b0, sig_rnd[24]};

    always_comb begin
        if (x_nan || y_nan || (x_inf && y_inf && (x_sign != y_sign))) begin
            res = `FPU_CANON_NAN;
        end else if (x_inf) begin
            res = {x_sign, 8'hff, 23'b0};
        end else if (y_inf) begin
            res = {y_sign, 8'hff, 23'b0};
        end else if (sum == '0) begin
            // Exact cancellation is +0 unless both addends were negative.
            res = {x_sign & y_sign, 31'b0};
        end else if (!exp_rnd[9] && (exp_rnd >= 10'd255)) begin
            res = {a_sign, 8'hff, 23'b0};
        end else if (exp_rnd[9] || (exp_rnd == '0)) begin
            res = {a_sign, 31'b0};
        end else begin
            res = {a_sign, exp_rnd[7:0], sig_rnd[22:0]};
        end
    end

    // A nonzero sum leaves the shifter with its leading one at bit 27.
    assert final ($isunknown({x, y, sub}) || (sum == '0) || norm[27])
        else $error("fpu_add: sum is not normalized");

endmodule

`default_nettype wire

/* src/fpu_mul.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_mul
    import fpu_pkg::*;
    (
        input fp_word_t x,
        input fp_word_t y,
        output fp_word_t res
    );

    logic x_sign, y_sign, r_sign;
    fp_exp_t x_exp, y_exp;
    fp_mant_t x_mant, y_mant;
    logic x_zero, y_zero, x_inf, y_inf, x_nan, y_nan;
    fp_sig_t x_sig, y_sig, norm_sig;
    logic [47:0] prod;
    logic guard, sticky, round_up;
    logic [24:0] sig_rnd;
    logic [9:0] exp_sum, exp_rnd;

    assign x_sign = x[31];
    assign y_sign = y[31];
    assign r_sign = x_sign ^ y_sign;
    assign x_exp = x[30:23];
    assign y_exp = y[30:23];
    assign x_mant = x[22:0];
    assign y_mant = y[22:0];

    assign x_zero = (x_exp == '0);
    assign y_zero = (y_exp == '0);
    assign x_inf = (&x_exp) && (x_mant == '0);
    assign y_inf = (&y_exp) && (y_mant == '0);
    assign x_nan = (&x_exp) && (x_mant != '0);
    assign y_nan = (&y_exp) && (y_mant != '0);

    assign x_sig = {1'b1, x_mant};
    assign y_sig = {1'b1, y_mant};
    assign prod = x_sig * y_sig;

    // The product of two normal significands lies in [1, 4), so at most one
    // position of normalization is needed.
    assign norm_sig = prod[47] ? prod[47:24] : prod[46:23];
    assign guard = prod[47] ? prod[23] : prod[22];
    assign sticky = prod[47] ? (|prod[22:0]) : (|prod[21:0]);
    assign round_up = guard & (sticky | norm_sig[0]);
    assign sig_rnd = {1'b0, norm_sig} + {24'b0, round_up};

    assign exp_sum = {2'b0, x_exp} + {2'b0, y_exp} - 10'(`FPU_EXP_BIAS)
                     + {9'b0, prod[47]};
    assign exp_rnd = exp_sum + {9'b0, sig_rnd[24]};

    always_comb begin
        if (x_nan || y_nan || (x_zero && y_inf) || (x_inf && y_zero)) begin
            res = `FPU_CANON_NAN;
        end else if (x_inf || y_inf) begin
            res = {r_sign, 8'hff, 23'b0};
        end else if (x_zero || y_zero) begin
            res = {r_sign, 31'b0};
        end else if (!exp_rnd[9] && (exp_rnd >= 10'd255)) begin
            res = {r_sign, 8'hff, 23'b0};
        end else if (exp_rnd[9] || (exp_rnd == '0)) begin
            // Results below the normal range flush to zero.
            res = {r_sign, 31'b0};
        end else begin
            res = {r_sign, exp_rnd[7:0], sig_rnd[22:0]};
        end
    end

endmodule

`default_nettype wire

/* src/fpu_sign_cmp.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_sign_cmp
    import fpu_pkg::*;
    (
        input fp_word_t x,
        input fp_word_t y,
        input fp_rm_t rm,
        output fp_word_t sgnj_res,
        output fp_word_t cmp_res
    );

    logic x_sign, y_sign;
    logic x_zero, y_zero, x_nan, y_nan, any_nan;
    logic [30:0] x_mag, y_mag;
    logic is_eq, is_lt, is_le;

    assign x_sign = x[31];
    assign y_sign = y[31];

    always_comb begin
        case (rm)
            `FPU_RM_SGNJ: sgnj_res = {y_sign, x[30:0]};
            `FPU_RM_SGNJN: sgnj_res = {~y_sign, x[30:0]};
            `FPU_RM_SGNJX: sgnj_res = {x_sign ^ y_sign, x[30:0]};
            default: sgnj_res = '0;
        endcase
    end

    assign x_zero = (x[30:23] == '0);
    assign y_zero = (y[30:23] == '0);
    assign x_nan = (&x[30:23]) && (x[22:0] != '0);
    assign y_nan = (&y[30:23]) && (y[22:0] != '0);
    assign any_nan = x_nan | y_nan;

    assign x_mag = x_zero ? '0 : x[30:0];
    assign y_mag = y_zero ? '0 : y[30:0];

    // Zeros of either sign are one value.
    assign is_eq = !any_nan && ((x_zero && y_zero) || ((x_sign == y_sign) && (x_mag == y_mag)));

    always_comb begin
        if (any_nan || (x_zero && y_zero)) begin
            is_lt = 1'b0;
        end else if (x_sign != y_sign) begin
            is_lt = x_sign;
        end else if (x_sign) begin
            is_lt = (x_mag > y_mag);
        end else begin
            is_lt = (x_mag < y_mag);
        end
    end

    assign is_le = is_lt | is_eq;

    always_comb begin
        case (rm)
            `FPU_RM_FEQ: cmp_res = {31'b0, is_eq};
            `FPU_RM_FLT: cmp_res = {31'b0, is_lt};
            `FPU_RM_FLE: cmp_res = {31'b0, is_le};
            default: cmp_res = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/fpu_convert.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_convert
    import fpu_pkg::*;
    (
        input fp_word_t x,
        output fp_word_t to_int,
        output fp_word_t to_float
    );

    logic f_sign, f_nan;
    fp_exp_t f_exp;
    fp_sig_t f_sig;
    logic [5:0] f_shamt;
    logic [63:0] f_fixed;
    fp_word_t f_int, f_mag;
    logic f_guard, f_sticky, f_round;

    logic i_sign, i_guard, i_sticky, i_round;
    fp_word_t i_mag, i_norm;
    logic [5:0] i_lz;
    logic [24:0] i_sig_rnd;
    fp_exp_t i_exp;

    function automatic logic [5:0] lead_zeros(input fp_word_t v);
        logic [5:0] n;
        logic found;
        n = '0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 6'd1;
                end
            end
        end
        return n;
    endfunction

    assign f_sign = x[31];
    assign f_exp = x[30:23];
    assign f_sig = {1'b1, x[22:0]};
    assign f_nan = (&f_exp) && (x[22:0] != '0);

    // Fixed point with the binary point between bits 32 and 31. Only
    // exponents from bias-1 to bias+30 reach this path.
    assign f_shamt = 6'(f_exp - 8'(`FPU_EXP_BIAS - 9));
    assign f_fixed = {40'b0, f_sig} << f_shamt;
    assign f_int = f_fixed[63:32];
    assign f_guard = f_fixed[31];
    assign f_sticky = |f_fixed[30:0];
    assign f_round = f_guard & (f_sticky | f_int[0]);
    assign f_mag = f_int + {31'b0, f_round};

    always_comb begin
        if (f_nan) begin
            to_int = 32'h7fffffff;
        end else if (f_exp >= 8'(`FPU_EXP_BIAS + 31)) begin
            to_int = f_sign ? 32'h80000000 : 32'h7fffffff;
        end else if (f_exp < 8'(`FPU_EXP_BIAS - 1)) begin
            to_int = '0;
        end else begin
            to_int = f_sign ? -f_mag : f_mag;
        end
    end

    // The most negative integer keeps its bit pattern as a magnitude.
    assign i_sign = x[31];
    assign i_mag = i_sign ? -x : x;
    assign i_lz = lead_zeros(i_mag);
    assign i_norm = i_mag << i_lz;

    assign i_guard = i_norm[7];
    assign i_sticky = |i_norm[6:0];
    assign i_round = i_guard & (i_sticky | i_norm[8]);
    assign i_sig_rnd = {1'b0, i_norm[31:8]} + {24'b0, i_round};
    assign i_exp = 8'(`FPU_EXP_BIAS + 31) - {2'b0, i_lz} + {7'b0, i_sig_rnd[24]};

    assign to_float = (i_mag == '0) ? '0 : {i_sign, i_exp, i_sig_rnd[22:0]};

endmodule

`default_nettype wire

/* src/fpu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu
    import fpu_pkg::*;
    (
        input logic clk,
        input logic reset,
        input fp_word_t x,
        input fp_word_t y,
        input fp_funct_t funct5,
        input fp_rm_t rm,
        output fp_word_t res
    );

    logic sub;
    fp_word_t add_res, mul_res, sgnj_res, cmp_res, to_int, to_float;
    fp_word_t res_next;

    assign sub = (funct5 == `FPU_OP_FSUB);

    fpu_add u_fadd (.x(x), .y(y), .sub(sub), .res(add_res));

    fpu_mul u_fmul (.x(x), .y(y), .res(mul_res));

    fpu_sign_cmp u_fsign_cmp (
        .x(x),
        .y(y),
        .rm(rm),
        .sgnj_res(sgnj_res),
        .cmp_res(cmp_res)
    );

    fpu_convert u_fconv (.x(x), .to_int(to_int), .to_float(to_float));

    // The rm variant is already chosen inside the sign and compare unit.
    always_comb begin
        case (funct5)
            `FPU_OP_FADD, `FPU_OP_FSUB: res_next = add_res;
            `FPU_OP_FMUL: res_next = mul_res;
            `FPU_OP_FSGNJ: res_next = sgnj_res;
            `FPU_OP_FCMP: res_next = cmp_res;
            `FPU_OP_FTOI: res_next = to_int;
            `FPU_OP_ITOF: res_next = to_float;
            default: res_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res <= '0;
        end else begin
            res <= res_next;
        end
    end

    a_funct5_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(funct5))
        else $error("fpu: funct5 has unknown bits");

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
    output logic clk
);

    // Free-running clock with a 10 ns period, starting low.
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

/* dv/fpu_tb.sv */
`timescale 1ns/10ps
`include "fpu_consts.svh"

module fpu_tb
    import fpu_pkg::*;
    ();

    localparam int NUM_ROWS = 30;
    localparam int NUM_RANDOM = 16;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT = NUM_ROWS + NUM_RANDOM + RESET_CYCLES + 20;

    logic clk;
    logic reset;
    fp_word_t x, y, res;
    fp_funct_t funct5;
    fp_rm_t rm;

    int seed;
    int pass_count, fail_count;
    int row_count;
    int cycle_count;

    fp_funct_t t_op [NUM_ROWS];
    fp_rm_t t_rm [NUM_ROWS];
    fp_word_t t_x [NUM_ROWS];
    fp_word_t t_y [NUM_ROWS];
    fp_word_t t_exp [NUM_ROWS];
    string t_name [NUM_ROWS];

    clock_gen clk_gen_i (.clk(clk));

    fpu dut_i (.clk(clk), .reset(reset), .x(x), .y(y), .funct5(funct5), .rm(rm), .res(res));

    // Zeros of both signs map to 0, every other value to its signed magnitude.
    function automatic longint order_key(input fp_word_t v);
        longint mag;
        mag = (v[30:23] == 8'h00) ? 0 : longint'(v[30:0]);
        return v[31] ? -mag : mag;
    endfunction

    function automatic fp_word_t expected_compare(input fp_rm_t sel, input fp_word_t a,
                                                  input fp_word_t b);
        logic unordered;
        unordered = (&a[30:23] && a[22:0] != '0) || (&b[30:23] && b[22:0] != '0);
        case (sel)
            `FPU_RM_FEQ: return {31'b0, !unordered && order_key(a) == order_key(b)};
            `FPU_RM_FLT: return {31'b0, !unordered && order_key(a) < order_key(b)};
            `FPU_RM_FLE: return {31'b0, !unordered && order_key(a) <= order_key(b)};
            default: return '0;
        endcase
    endfunction

    function automatic fp_word_t expected_sign_inject(input fp_rm_t sel, input fp_word_t a,
                                                      input fp_word_t b);
        case (sel)
            `FPU_RM_SGNJ: return {b[31], a[30:0]};
            `FPU_RM_SGNJN: return {~b[31], a[30:0]};
            `FPU_RM_SGNJX: return {a[31] ^ b[31], a[30:0]};
            default: return '0;
        endcase
    endfunction

    task automatic add_row(input fp_funct_t op, input fp_rm_t sel, input fp_word_t a,
                           input fp_word_t b, input fp_word_t expected, input string name);
        t_op[row_count] = op;
        t_rm[row_count] = sel;
        t_x[row_count] = a;
        t_y[row_count] = b;
        t_exp[row_count] = expected;
        t_name[row_count] = name;
        row_count++;
    endtask

    task automatic check_res(input string name, input fp_word_t expected);
        if (res !== expected) begin
            $display("error: %s: res expected %h, got %h", name, expected, res);
            fail_count++;
        end else begin
            $display("ok: %s: res = %h", name, res);
            pass_count++;
        end
    endtask

    // Called on a falling edge; the result is due at the next falling edge.
    task automatic run_op(input fp_funct_t op, input fp_rm_t sel, input fp_word_t a,
                          input fp_word_t b, input fp_word_t expected, input string name);
        funct5 = op;
        rm = sel;
        x = a;
        y = b;
        @(negedge clk);
        check_res(name, expected);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        int kind;
        fp_funct_t rnd_op;
        fp_rm_t rnd_rm;
        fp_word_t rnd_x, rnd_y, rnd_exp;

        seed = 35;
        pass_count = 0;
        fail_count = 0;
        row_count = 0;
        // An add sits on the inputs so that reset visibly holds the result.
        reset = 1'b1;
        funct5 = `FPU_OP_FADD;
        rm = 3'b000;
        x = 32'h3f800000;
        y = 32'h40000000;

        add_row(`FPU_OP_FADD, 0, 'h3f800000, 'h40000000, 'h40400000, "add 1 + 2");
        add_row(`FPU_OP_FADD, 0, 'h40a00000, 'hc0400000, 'h40000000, "add 5 + -3");
        add_row(`FPU_OP_FADD, 0, 'h3f800000, 'h33800000, 'h3f800000, "add tie down");
        add_row(`FPU_OP_FADD, 0, 'h3f800001, 'h33800000, 'h3f800002, "add tie up");
        add_row(`FPU_OP_FSUB, 0, 'h3fc00000, 'h3fc00000, 'h00000000, "sub to zero");
        add_row(`FPU_OP_FSUB, 0, 'h7f800000, 'h7f800000, 'h7fc00000, "sub inf - inf");
        add_row(`FPU_OP_FADD, 0, 'h7f7fffff, 'h7f7fffff, 'h7f800000, "add overflow");
        add_row(`FPU_OP_FADD, 0, 'h00800000, 'h00400000, 'h00800000, "add subnormal flush");
        add_row(`FPU_OP_FMUL, 0, 'h40000000, 'h40400000, 'h40c00000, "mul 2 * 3");
        add_row(`FPU_OP_FMUL, 0, 'h3f800001, 'h3fc00000, 'h3fc00002, "mul round up");
        add_row(`FPU_OP_FMUL, 0, 'h00000000, 'h7f800000, 'h7fc00000, "mul 0 * inf");
        add_row(`FPU_OP_FMUL, 0, 'h0d800000, 'h0d800000, 'h00000000, "mul underflow");
        add_row(`FPU_OP_FSGNJ, `FPU_RM_SGNJ, 'h3f800000, 'hc0000000, 'hbf800000, "fsgnj");
        add_row(`FPU_OP_FSGNJ, `FPU_RM_SGNJN, 'h3f800000, 'hc0000000, 'h3f800000, "fsgnjn");
        add_row(`FPU_OP_FSGNJ, `FPU_RM_SGNJX, 'hbf800000, 'hc0000000, 'h3f800000, "fsgnjx");
        add_row(`FPU_OP_FCMP, `FPU_RM_FEQ, 'h00000000, 'h80000000, 'h1, "feq +0 -0");
        add_row(`FPU_OP_FCMP, `FPU_RM_FLT, 'h00000000, 'h80000000, 'h0, "flt +0 -0");
        add_row(`FPU_OP_FCMP, `FPU_RM_FLE, 'h80000000, 'h00000000, 'h1, "fle -0 +0");
        add_row(`FPU_OP_FCMP, `FPU_RM_FLT, 'h3f800000, 'h40000000, 'h1, "flt 1 2");
        add_row(`FPU_OP_FCMP, `FPU_RM_FLE, 'h40000000, 'h3f800000, 'h0, "fle 2 1");
        add_row(`FPU_OP_FCMP, `FPU_RM_FEQ, 'h7fc00000, 'h7fc00000, 'h0, "feq nan nan");
        add_row(`FPU_OP_FCMP, `FPU_RM_FLT, 'h3f800000, 'h7f800001, 'h0, "flt 1 nan");
        add_row(`FPU_OP_ITOF, 0, 'h00000001, 'h0, 'h3f800000, "itof 1");
        add_row(`FPU_OP_ITOF, 0, 'hfffffffb, 'h0, 'hc0a00000, "itof -5");
        add_row(`FPU_OP_ITOF, 0, 'h01000001, 'h0, 'h4b800000, "itof 2^24+1");
        add_row(`FPU_OP_FTOI, 0, 'h40200000, 'h0, 'h00000002, "ftoi 2.5");
        add_row(`FPU_OP_FTOI, 0, 'h40600000, 'h0, 'h00000004, "ftoi 3.5");
        add_row(`FPU_OP_FTOI, 0, 'h53800000, 'h0, 'h7fffffff, "ftoi 2^40");
        add_row(`FPU_OP_FTOI, 0, 'h7fc00000, 'h0, 'h7fffffff, "ftoi nan");
        add_row(5'b00011, 0, 'h3f800000, 'h3f800000, 'h00000000, "unlisted funct5");

        @(posedge clk);
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_res("during reset", '0);
        end
        reset = 1'b0;
        funct5 = 5'b11111;
        @(negedge clk);
        check_res("first cycle after reset", '0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_op(t_op[i], t_rm[i], t_x[i], t_y[i], t_exp[i], t_name[i]);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_x = $random(seed);
            rnd_y = $random(seed);
            kind = $random(seed) & 3;
            // Bias toward equal values, signed zeros and NaNs.
            case (kind)
                0: rnd_y = rnd_x;
                1: begin
                    rnd_x = {rnd_x[31], 31'b0};
                    rnd_y = {rnd_y[31], 31'b0};
                end
                2: rnd_y = {rnd_y[31], 8'hff, 1'b1, rnd_y[21:0]};
                default: ;
            endcase
            rnd_rm = 3'($unsigned($random(seed)) % 3);
            if (($random(seed) & 1) != 0) begin
                rnd_op = `FPU_OP_FSGNJ;
                rnd_exp = expected_sign_inject(rnd_rm, rnd_x, rnd_y);
            end else begin
                rnd_op = `FPU_OP_FCMP;
                rnd_exp = expected_compare(rnd_rm, rnd_x, rnd_y);
            end
            run_op(rnd_op, rnd_rm, rnd_x, rnd_y, rnd_exp, $sformatf("random %0d", i));
        end

        $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+src
src/fpu_pkg.sv
src/fpu_add.sv
src/fpu_mul.sv
src/fpu_sign_cmp.sv
src/fpu_convert.sv
src/fpu.sv
dv/clock_gen.sv
dv/fpu_tb.sv
